/* idiv_iterative.f */
+incdir+src
src/idiv_dp_pkg.sv
src/idiv_ctrl_pkg.sv
src/idiv_controller.sv
src/idiv_datapath.sv
src/idiv_iterative.sv
verif/tb_clock_gen.sv
verif/tb_idiv_iterative.sv

/* Bender.yml */
package:
  name: idiv_iterative

sources:
  - include_dirs:
      - src
    files:
      - src/idiv_dp_pkg.sv
      - src/idiv_ctrl_pkg.sv
      - src/idiv_controller.sv
      - src/idiv_datapath.sv
      - src/idiv_iterative.sv

  - target: test
    include_dirs:
      - src
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_idiv_iterative.sv

/* verif/tb_idiv_iterative.sv */
/*
  Testbench for the iterative divider. One request at a time, inputs change
  on the falling edge, results are checked on the rising edge at yumi.
*/

`include "idiv_params.svh"

module tb_idiv_iterative;

    timeunit 1ns;
    timeprecision 1ps;

    import idiv_dp_pkg::*;

    localparam int max_yumi_delay   = 12;
    localparam int num_directed     = 13;
    localparam int num_random       = 300;
    localparam int num_backpressure = 40;
    localparam int num_ops          = num_directed + num_random + num_backpressure;
    localparam int watchdog_cycles  = num_ops * (`IDIV_WIDTH + 8 + max_yumi_delay + 4)
                                    + 10 + `IDIV_WIDTH + 40;

    localparam idiv_word_t word_min = {1'b1, {(`IDIV_WIDTH-1){1'b0}}};

    logic       clk;
    logic       reset;
    logic       req_valid;
    logic       req_ready;
    idiv_word_t dividend;
    idiv_word_t divisor;
    logic       is_signed;
    logic       res_valid;
    idiv_word_t quotient;
    idiv_word_t remainder;
    logic       yumi;

    integer     seed;
    string      test_name;
    int         yumi_delay  = 0;
    bit         bp_mode     = 1'b0;
    int         outstanding = 0;

    string      name_q[$];
    idiv_word_t quo_q[$];
    idiv_word_t rem_q[$];

    tb_clock_gen u_clk (
        .clk_o   (clk),
        .reset_o (reset)
    );

    idiv_iterative DUT (
        .clk_i       (clk),
        .reset_i     (reset),
        .valid_i     (req_valid),
        .ready_and_o (req_ready),
        .dividend_i  (dividend),
        .divisor_i   (divisor),
        .signed_i    (is_signed),
        .valid_o     (res_valid),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .yumi_i      (yumi)
    );

    // ========================================
    // reference model and checks
    // ========================================

    // returns {quotient, remainder}, computed on magnitudes one bit wider
    function automatic logic [2*`IDIV_WIDTH-1:0] expected_result(
        input idiv_word_t a, input idiv_word_t b, input logic sgn);
        logic [`IDIV_WIDTH:0] mag_a;
        logic [`IDIV_WIDTH:0] mag_b;
        logic [`IDIV_WIDTH:0] mag_q;
        logic [`IDIV_WIDTH:0] mag_r;
        logic                 neg_a;
        logic                 neg_b;
        idiv_word_t           q;
        idiv_word_t           r;
        neg_a = sgn & a[`IDIV_WIDTH-1];
        neg_b = sgn & b[`IDIV_WIDTH-1];
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (sgn && a == word_min && b == '1) begin
            q = a;
            r = '0;
        end else begin
            mag_a = neg_a ? (~{1'b1, a} + 1'b1) : {1'b0, a};
            mag_b = neg_b ? (~{1'b1, b} + 1'b1) : {1'b0, b};
            mag_q = mag_a / mag_b;
            mag_r = mag_a % mag_b;
            q = mag_q[`IDIV_WIDTH-1:0];
            r = mag_r[`IDIV_WIDTH-1:0];
            // truncation toward zero, remainder follows the dividend
            if (neg_a ^ neg_b) q = ~q + 1'b1;
            if (neg_a) r = ~r + 1'b1;
        end
        return {q, r};
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic quotient_check(input string name, input idiv_word_t exp_v,
                                  input idiv_word_t act_v);
        if (act_v !== exp_v) begin
            stop_run($sformatf("FAILED %s quotient: expected %h, actual %h",
                               name, exp_v, act_v));
        end
    endtask

    task automatic remainder_check(input string name, input idiv_word_t exp_v,
                                   input idiv_word_t act_v);
        if (act_v !== exp_v) begin
            stop_run($sformatf("FAILED %s remainder: expected %h, actual %h",
                               name, exp_v, act_v));
        end
    endtask

    // ========================================
    // monitor
    // ========================================

    always @(posedge clk) begin : monitor
        logic [2*`IDIV_WIDTH-1:0] pair;
        bit                       busy;
        bit                       held;
        idiv_word_t               held_q;
        idiv_word_t               held_r;
        if (!reset) begin
            if (busy && req_ready) stop_run("ready_and_o rose before the result was taken");
            if (held && !res_valid) stop_run("valid_o dropped before yumi_i");
            if (held && (quotient !== held_q || remainder !== held_r)) begin
                stop_run("outputs changed while valid_o waited for yumi_i");
            end
            if (req_valid && req_ready) begin
                pair = expected_result(dividend, divisor, is_signed);
                name_q.push_back(test_name);
                quo_q.push_back(pair[2*`IDIV_WIDTH-1:`IDIV_WIDTH]);
                rem_q.push_back(pair[`IDIV_WIDTH-1:0]);
                outstanding++;
                busy = 1'b1;
            end
            if (res_valid && yumi) begin
                if (name_q.size() == 0) stop_run("a result appeared without a request");
                quotient_check(name_q[0], quo_q.pop_front(), quotient);
                remainder_check(name_q.pop_front(), rem_q.pop_front(), remainder);
                outstanding--;
                busy = 1'b0;
            end
            held   = res_valid && !yumi;
            held_q = quotient;
            held_r = remainder;
        end
    end

    // consumer, takes each result after the delay chosen at issue
    initial begin : consumer
        yumi = 1'b0;
        forever begin
            @(negedge clk);
            yumi = 1'b0;
            if (!reset && res_valid) begin
                repeat (yumi_delay) @(negedge clk);
                yumi = 1'b1;
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk);
        stop_run("divider stopped responding, watchdog time ran out");
    end

    // ========================================
    // stimulus
    // ========================================

    task automatic issue_op(input string name, input idiv_word_t a,
                            input idiv_word_t b, input logic sgn);
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        yumi_delay = bp_mode ? ($unsigned($random(seed)) % (max_yumi_delay + 1)) : 0;
        test_name  = name;
        dividend   = a;
        divisor    = b;
        is_signed  = sgn;
        req_valid  = 1'b1;
        @(negedge clk);
        req_valid  = 1'b0;
    endtask

    initial begin : stimulus
        idiv_word_t a;
        idiv_word_t b;
        seed      = 32'hd2b7;
        test_name = "reset";
        req_valid = 1'b0;
        dividend  = '0;
        divisor   = '0;
        is_signed = 1'b0;

        // request during reset must be ignored
        repeat (3) @(negedge clk);
        dividend  = 100;
        divisor   = 7;
        req_valid = 1'b1;
        repeat (4) @(negedge clk);
        req_valid = 1'b0;
        while (reset) @(negedge clk);
        if (!req_ready || res_valid) stop_run("divider not idle after reset");
        repeat (`IDIV_WIDTH + 10) begin
            @(negedge clk);
            if (res_valid) stop_run("request made during reset produced a result");
        end

        issue_op("unsigned_small", 100, 7, 1'b0);
        issue_op("unsigned_equal", 42, 42, 1'b0);
        issue_op("unsigned_dividend_smaller", 5, 9, 1'b0);
        issue_op("unsigned_divisor_one", 12345, 1, 1'b0);
        issue_op("unsigned_all_ones", '1, 3, 1'b0);

        issue_op("signed_pos_pos", 100, 7, 1'b1);
        issue_op("signed_neg_pos", idiv_word_t'(-100), 7, 1'b1);
        issue_op("signed_pos_neg", 100, idiv_word_t'(-7), 1'b1);
        issue_op("signed_neg_neg", idiv_word_t'(-100), idiv_word_t'(-7), 1'b1);

        issue_op("unsigned_zero_divisor", 1234, 0, 1'b0);
        issue_op("signed_zero_divisor", idiv_word_t'(-1234), 0, 1'b1);
        issue_op("signed_min_by_minus_one", word_min, '1, 1'b1);
        issue_op("unsigned_min_by_all_ones", word_min, '1, 1'b0);

        for (int i = 0; i < num_random; i++) begin
            a = $random(seed);
            b = $random(seed);
            // shorter divisors give larger quotients
            b = b >> ($unsigned($random(seed)) % `IDIV_WIDTH);
            issue_op($sformatf("random_%0d", i), a, b, $random(seed) & 1);
        end

        bp_mode = 1'b1;
        for (int i = 0; i < num_backpressure; i++) begin
            a = $random(seed);
            b = $random(seed);
            b = b >> ($unsigned($random(seed)) % `IDIV_WIDTH);
            issue_op($sformatf("backpressure_%0d", i), a, b, $random(seed) & 1);
        end

        while (outstanding != 0) @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

/* verif/tb_clock_gen.sv */
/*
  Testbench clock, 20 ns period. Reset is high for the first 10 rising
  edges and drops on the following falling edge.
*/

module tb_clock_gen (
    output logic clk_o,
    output logic reset_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

/* src/idiv_iterative.sv */
/*
  Iterative divider, one quotient bit per cycle. Results are held under
  valid_o until yumi_i. No new request is taken while a result waits.
*/

module idiv_iterative (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  logic                    valid_i,
    output logic                    ready_and_o,
    input  idiv_dp_pkg::idiv_word_t dividend_i,
    input  idiv_dp_pkg::idiv_word_t divisor_i,
    input  logic                    signed_i,

    output logic                    valid_o,
    output idiv_dp_pkg::idiv_word_t quotient_o,
    output idiv_dp_pkg::idiv_word_t remainder_o,
    input  logic                    yumi_i
);

    import idiv_ctrl_pkg::*;

    // control, controller to datapath
    opa_sel_e opa_sel;
    logic     opa_ld;
    logic     opa_inv;
    logic     opa_clr_l;
    opb_sel_e opb_sel;
    logic     opb_ld;
    logic     opb_inv;
    logic     opb_clr_l;
    opc_sel_e opc_sel;
    logic     opc_ld;
    logic     latch_signed;
    logic     adder_cin;

    // status, datapath to controller
    logic     zero_divisor;
    logic     signed_div_r;
    logic     adder_neg;
    logic     opa_neg;
    logic     opc_neg;

    idiv_controller u_ctrl (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .valid_i        (valid_i),
        .ready_and_o    (ready_and_o),
        .zero_divisor_i (zero_divisor),
        .signed_div_r_i (signed_div_r),
        .adder_neg_i    (adder_neg),
        .opa_neg_i      (opa_neg),
        .opc_neg_i      (opc_neg),
        .opa_sel_o      (opa_sel),
        .opa_ld_o       (opa_ld),
        .opa_inv_o      (opa_inv),
        .opa_clr_l_o    (opa_clr_l),
        .opb_sel_o      (opb_sel),
        .opb_ld_o       (opb_ld),
        .opb_inv_o      (opb_inv),
        .opb_clr_l_o    (opb_clr_l),
        .opc_sel_o      (opc_sel),
        .opc_ld_o       (opc_ld),
        .latch_signed_o (latch_signed),
        .adder_cin_o    (adder_cin),
        .valid_o        (valid_o),
        .yumi_i         (yumi_i)
    );

    idiv_datapath u_dp (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .dividend_i     (dividend_i),
        .divisor_i      (divisor_i),
        .signed_i       (signed_i),
        .opa_sel_i      (opa_sel),
        .opa_ld_i       (opa_ld),
        .opa_inv_i      (opa_inv),
        .opa_clr_l_i    (opa_clr_l),
        .opb_sel_i      (opb_sel),
        .opb_ld_i       (opb_ld),
        .opb_inv_i      (opb_inv),
        .opb_clr_l_i    (opb_clr_l),
        .opc_sel_i      (opc_sel),
        .opc_ld_i       (opc_ld),
        .latch_signed_i (latch_signed),
        .adder_cin_i    (adder_cin),
        .zero_divisor_o (zero_divisor),
        .signed_div_r_o (signed_div_r),
        .adder_neg_o    (adder_neg),
        .opa_neg_o      (opa_neg),
        .opc_neg_o      (opc_neg),
        .quotient_o     (quotient_o),
        .remainder_o    (remainder_o)
    );

endmodule

/* src/idiv_datapath.sv */
/*
  Operand registers and the single adder of the divider. A and B are one bit
  wider than an operand. The remainder ends up in A, the quotient in C.
*/

`include "idiv_params.svh"

module idiv_datapath (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  idiv_dp_pkg::idiv_word_t dividend_i,
    input  idiv_dp_pkg::idiv_word_t divisor_i,
    input  logic                    signed_i,

    input  idiv_ctrl_pkg::opa_sel_e opa_sel_i,
    input  logic                    opa_ld_i,
    input  logic                    opa_inv_i,
    input  logic                    opa_clr_l_i,

    input  idiv_ctrl_pkg::opb_sel_e opb_sel_i,
    input  logic                    opb_ld_i,
    input  logic                    opb_inv_i,
    input  logic                    opb_clr_l_i,

    input  idiv_ctrl_pkg::opc_sel_e opc_sel_i,
    input  logic                    opc_ld_i,

    input  logic                    latch_signed_i,
    input  logic                    adder_cin_i,

    output logic                    zero_divisor_o,
    output logic                    signed_div_r_o,
    output logic                    adder_neg_o,
    output logic                    opa_neg_o,
    output logic                    opc_neg_o,

    output idiv_dp_pkg::idiv_word_t quotient_o,
    output idiv_dp_pkg::idiv_word_t remainder_o
);

    import idiv_dp_pkg::*;
    import idiv_ctrl_pkg::*;

    idiv_ext_t   opa_r;
    idiv_shift_u bc_r;
    logic        signed_div_r;

    idiv_ext_t   divisor_ext;
    idiv_ext_t   opa_op;
    idiv_ext_t   opb_op;
    idiv_ext_t   add_out;
    idiv_shift_u shift_w;

    idiv_ext_t   opa_mux;
    idiv_ext_t   opb_mux;
    idiv_word_t  opc_mux;

    // ========================================
    // adder
    // ========================================

    // sign extension only for signed requests
    assign divisor_ext = {signed_i & divisor_i[`IDIV_WIDTH-1], divisor_i};

    assign opa_op  = (opa_r ^ {(`IDIV_WIDTH+1){opa_inv_i}})
                   & {(`IDIV_WIDTH+1){opa_clr_l_i}};
    assign opb_op  = (bc_r.parts.rem ^ {(`IDIV_WIDTH+1){opb_inv_i}})
                   & {(`IDIV_WIDTH+1){opb_clr_l_i}};
    assign add_out = opa_op + opb_op + idiv_ext_t'(adder_cin_i);

    // adder result and C move up one place, new quotient bit enters at the bottom
    assign shift_w.raw = {add_out[`IDIV_WIDTH-1:0], bc_r.parts.quo, ~add_out[`IDIV_WIDTH]};

    // ========================================
    // input multiplexers
    // ========================================

    always_comb begin
        case (opa_sel_i)
            OPA_DIVISOR: opa_mux = divisor_ext;
            default:     opa_mux = add_out;
        endcase
    end

    always_comb begin
        case (opb_sel_i)
            OPB_SHIFT: opb_mux = shift_w.parts.rem;
            OPB_ADD:   opb_mux = add_out;
            default:   opb_mux = {1'b0, bc_r.parts.quo};
        endcase
    end

    always_comb begin
        case (opc_sel_i)
            OPC_SHIFT: opc_mux = shift_w.parts.quo;
            OPC_ADD:   opc_mux = add_out[`IDIV_WIDTH-1:0];
            default:   opc_mux = dividend_i;
        endcase
    end

    // ========================================
    // registers
    // ========================================

    always_ff @(posedge clk_i) begin
        if (opa_ld_i) begin
            opa_r <= opa_mux;
        end
        if (opb_ld_i) begin
            bc_r.parts.rem <= opb_mux;
        end
        if (opc_ld_i) begin
            bc_r.parts.quo <= opc_mux;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            signed_div_r <= 1'b0;
        end else if (latch_signed_i) begin
            signed_div_r <= signed_i;
        end
    end

    // ========================================
    // status and results
    // ========================================

    assign zero_divisor_o = ~|opa_r;
    assign signed_div_r_o = signed_div_r;
    assign adder_neg_o    = add_out[`IDIV_WIDTH];
    assign opa_neg_o      = opa_r[`IDIV_WIDTH];
    assign opc_neg_o      = bc_r.parts.quo[`IDIV_WIDTH-1];

    assign quotient_o  = bc_r.parts.quo;
    assign remainder_o = opa_r[`IDIV_WIDTH-1:0];

    // A must load the raw divisor in the same cycle that C takes the dividend
    a_dividend_load_clean: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (opc_ld_i && opc_sel_i == OPC_DIVIDEND) |-> opa_clr_l_i)
        else $error("operand A cleared during dividend load");

endmodule

/* src/idiv_controller.sv */
/*
  Sequencer of the iterative divider. One operation in flight only.
  Status inputs are read combinationally from the datapath in the same cycle.
*/

`include "idiv_params.svh"

module idiv_controller (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  logic                    valid_i,
    output logic                    ready_and_o,

    input  logic                    zero_divisor_i,
    input  logic                    signed_div_r_i,
    input  logic                    adder_neg_i,
    input  logic                    opa_neg_i,
    input  logic                    opc_neg_i,

    output idiv_ctrl_pkg::opa_sel_e opa_sel_o,
    output logic                    opa_ld_o,
    output logic                    opa_inv_o,
    output logic                    opa_clr_l_o,

    output idiv_ctrl_pkg::opb_sel_e opb_sel_o,
    output logic                    opb_ld_o,
    output logic                    opb_inv_o,
    output logic                    opb_clr_l_o,

    output idiv_ctrl_pkg::opc_sel_e opc_sel_o,
    output logic                    opc_ld_o,

    output logic                    latch_signed_o,
    output logic                    adder_cin_o,

    output logic                    valid_o,
    input  logic                    yumi_i
);

    import idiv_ctrl_pkg::*;

    localparam logic [`IDIV_CNT_WIDTH-1:0] calc_last = `IDIV_WIDTH;

    idiv_state_e state_r;
    idiv_state_e state_n;

    logic q_neg_r;
    logic r_neg_r;
    logic neg_ld;
    logic add_neg_last_r;

    logic [`IDIV_CNT_WIDTH-1:0] calc_cnt_r;
    logic                       calc_up;
    logic                       calc_done;

    // ========================================
    // sign flags and step counter
    // ========================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            q_neg_r        <= 1'b0;
            r_neg_r        <= 1'b0;
            add_neg_last_r <= 1'b0;
        end else begin
            // picks add or subtract for the next non-restoring step
            add_neg_last_r <= adder_neg_i;
            if (neg_ld) begin
                // operand signs differ, so the quotient is negative
                q_neg_r <= (opa_neg_i ^ opc_neg_i) & signed_div_r_i;
                // remainder follows the dividend
                r_neg_r <= opc_neg_i & signed_div_r_i;
            end
        end
    end

    assign calc_up   = (state_r == CALC) && (calc_cnt_r < calc_last);
    assign calc_done = (calc_cnt_r == calc_last);

    always_ff @(posedge clk_i) begin
        if (reset_i || calc_done) begin
            calc_cnt_r <= '0;
        end else if (calc_up) begin
            calc_cnt_r <= calc_cnt_r + 1'b1;
        end
    end

    // ========================================
    // state machine
    // ========================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= WAIT;
        end else begin
            state_r <= state_n;
        end
    end

    always_comb begin
        // subtract after a positive step, add after a negative one
        opa_sel_o      = OPA_FEEDBACK;
        opa_ld_o       = 1'b0;
        opa_inv_o      = ~add_neg_last_r;
        opa_clr_l_o    = 1'b1;
        opb_sel_o      = OPB_SHIFT;
        opb_ld_o       = 1'b0;
        opb_inv_o      = 1'b0;
        opb_clr_l_o    = 1'b1;
        opc_sel_o      = OPC_SHIFT;
        opc_ld_o       = 1'b0;
        adder_cin_o    = ~add_neg_last_r;
        latch_signed_o = 1'b0;
        neg_ld         = 1'b0;
        state_n        = state_r;

        case (state_r)
            WAIT: begin
                opa_sel_o = OPA_DIVISOR;
                opc_sel_o = OPC_DIVIDEND;
                if (valid_i) begin
                    opa_ld_o       = 1'b1;
                    opc_ld_o       = 1'b1;
                    latch_signed_o = 1'b1;
                    state_n        = NEG0;
                end
            end
            NEG0: begin
                // A <= -A for a negative signed divisor, B <= copy of dividend
                opa_inv_o   = 1'b1;
                opb_clr_l_o = 1'b0;
                adder_cin_o = 1'b1;
                opa_ld_o    = opa_neg_i & signed_div_r_i;
                opb_sel_o   = OPB_COPY_C;
                opb_ld_o    = 1'b1;
                neg_ld      = 1'b1;
                state_n     = (opc_neg_i & signed_div_r_i) ? NEG1 : SHIFT;
            end
            NEG1: begin
                // C <= -B, the dividend magnitude
                opa_clr_l_o = 1'b0;
                opb_inv_o   = 1'b1;
                adder_cin_o = 1'b1;
                opc_sel_o   = OPC_ADD;
                opc_ld_o    = 1'b1;
                state_n     = SHIFT;
            end
            SHIFT: begin
                // adder gives zero: clears B and the last adder sign
                opa_clr_l_o = 1'b0;
                opb_clr_l_o = 1'b0;
                adder_cin_o = 1'b0;
                opb_sel_o   = OPB_ADD;
                opb_ld_o    = 1'b1;
                state_n     = CALC;
            end
            CALC: begin
                // the final step keeps the remainder unshifted
                opb_sel_o = calc_done ? OPB_ADD : OPB_SHIFT;
                opb_ld_o  = 1'b1;
                opc_ld_o  = 1'b1;
                if (calc_done) begin
                    state_n = adder_neg_i ? REPAIR : REMAIN;
                end
            end
            REPAIR: begin
                // B <= B + A
                opa_inv_o   = 1'b0;
                adder_cin_o = 1'b0;
                opb_sel_o   = OPB_ADD;
                opb_ld_o    = 1'b1;
                state_n     = REMAIN;
            end
            REMAIN: begin
                // signed remainder moves to A, quotient magnitude to B
                opa_clr_l_o = 1'b0;
                opb_inv_o   = r_neg_r;
                adder_cin_o = r_neg_r;
                opa_ld_o    = 1'b1;
                opb_sel_o   = OPB_COPY_C;
                opb_ld_o    = 1'b1;
                state_n     = (zero_divisor_i || !q_neg_r) ? DONE : QUOT;
            end
            QUOT: begin
                // C <= -B
                opa_clr_l_o = 1'b0;
                opb_inv_o   = 1'b1;
                adder_cin_o = 1'b1;
                opc_sel_o   = OPC_ADD;
                opc_ld_o    = 1'b1;
                state_n     = DONE;
            end
            DONE: begin
                if (yumi_i) begin
                    state_n = WAIT;
                end
            end
            default: begin
                state_n = WAIT;
            end
        endcase
    end

    assign ready_and_o = (state_r == WAIT);
    assign valid_o     = (state_r == DONE);

    // ========================================
    // checks
    // ========================================

    a_no_accept_while_valid: assert property (
        @(posedge clk_i) disable iff (reset_i) !(valid_o && ready_and_o))
        else $error("valid_o and ready_and_o high together");

    a_cnt_in_range: assert property (
        @(posedge clk_i) disable iff (reset_i) calc_cnt_r <= calc_last)
        else $error("step counter beyond operand width");

    a_yumi_needs_valid: assert property (
        @(posedge clk_i) disable iff (reset_i) yumi_i |-> valid_o)
        else $error("yumi_i without valid_o");

endmodule

/* src/idiv_ctrl_pkg.sv */
/*
  Controller types. Multiplexer selects are one-hot so that each bit
  picks exactly one source.
*/

package idiv_ctrl_pkg;

    // ========================================
    // controller states
    // ========================================

    typedef enum logic [3:0] {
        WAIT,
        NEG0,
        NEG1,
        SHIFT,
        CALC,
        REPAIR,
        REMAIN,
        QUOT,
        DONE
    } idiv_state_e;

    // ========================================
    // operand multiplexer selects
    // ========================================

    // register A: adder feedback or new divisor
    typedef enum logic [1:0] {
        OPA_FEEDBACK = 2'b01,
        OPA_DIVISOR  = 2'b10
    } opa_sel_e;

    // register B: shifted adder result, adder result, copy of C
    typedef enum logic [2:0] {
        OPB_SHIFT  = 3'b001,
        OPB_ADD    = 3'b010,
        OPB_COPY_C = 3'b100
    } opb_sel_e;

    // register C: shift in a quotient bit, adder result, new dividend
    typedef enum logic [2:0] {
        OPC_SHIFT    = 3'b001,
        OPC_ADD      = 3'b010,
        OPC_DIVIDEND = 3'b100
    } opc_sel_e;

endpackage

/* src/idiv_dp_pkg.sv */
/*
  Datapath types. The remainder field is one bit wider than an operand so
  that non-restoring partial remainders keep a valid sign bit.
*/

`include "idiv_params.svh"

package idiv_dp_pkg;

    // operand and result word
    typedef logic [`IDIV_WIDTH-1:0] idiv_word_t;

    // operand with one extra sign bit, width of A, B and the adder
    typedef logic [`IDIV_WIDTH:0] idiv_ext_t;

    // B (partial remainder) sits above C (quotient / dividend bits)
    typedef struct packed {
        idiv_ext_t  rem;
        idiv_word_t quo;
    } idiv_pair_t;

    // ========================================
    // shift word
    // ========================================

    // raw view is shifted left as one word during CALC,
    // parts view feeds register B, register C and the outputs
    typedef union packed {
        logic [2*`IDIV_WIDTH:0] raw;
        idiv_pair_t             parts;
    } idiv_shift_u;

endpackage

/* src/idiv_params.svh */
/*
  Width settings for the iterative divider. IDIV_WIDTH may be 8, 16 or 32.
  The step counter must reach IDIV_WIDTH itself, hence the +1.
*/

`ifndef IDIV_PARAMS_SVH
`define IDIV_PARAMS_SVH

// ========================================
// operand width
// ========================================

`define IDIV_WIDTH 32

// ========================================
// derived widths
// ========================================

// counts 0 .. IDIV_WIDTH inclusive during CALC
`define IDIV_CNT_WIDTH ($clog2(`IDIV_WIDTH + 1))

`endif
